// File: verilog/core_cfg_pkg.sv
/* sizing constants for the out-of-order back end, referenced by scoped name
   from every design file that needs a width or a depth */
package core_cfg_pkg;

    //////////////////////////////
    // datapath
    //////////////////////////////
    localparam int xlen = 32;
    localparam int reg_len = 5;

    // destination index that means no register write
    localparam logic [reg_len-1:0] zero_reg = '0;

    //////////////////////////////
    // reorder buffer
    //////////////////////////////
    localparam int rob_size = 8;
    localparam int tag_len = 3;

    //////////////////////////////
    // execution units
    //////////////////////////////
    // same depth as the rob, so credits keep a unit queue from overflowing
    localparam int unit_queue_depth = rob_size;
    localparam int alu_latency = 1;
    localparam int br_latency = 2;

endpackage

// File: verilog/core_types_pkg.sv
/* opcodes, unit kinds, unit states and the common data bus entry
   shared by the rob, the execution units and the arbiter */
package core_types_pkg;

    // instruction opcodes seen by the back end
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_beq,
        op_bne,
        op_halt
    } opcode_t;

    // selects which opcodes an execution unit accepts
    typedef enum logic {
        kind_alu,
        kind_branch
    } unit_kind_t;

    // compute and hold state of an execution unit
    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_hold
    } unit_state_t;

    // one result broadcast on the common data bus
    typedef struct packed {
        logic                             valid;
        logic [core_cfg_pkg::tag_len-1:0] tag;
        logic [core_cfg_pkg::xlen-1:0]    value;
        // branch outcome, low for alu results
        logic                             taken;
    } cdb_entry_t;

endpackage

// File: verilog/core_ifs.sv
/* interfaces inside the back end: issue from the rob to the units,
   and one result handshake per unit towards the cdb arbiter */
`timescale 1ns/10ps

// rob to units, no ready since credits guarantee queue space
interface issue_if;
    logic                             valid;
    core_types_pkg::opcode_t          opcode;
    logic [core_cfg_pkg::tag_len-1:0] tag;
    logic [core_cfg_pkg::xlen-1:0]    src_a;
    logic [core_cfg_pkg::xlen-1:0]    src_b;
    logic [core_cfg_pkg::xlen-1:0]    imm;
    logic [core_cfg_pkg::xlen-1:0]    pc;

    modport issuer (output valid, opcode, tag, src_a, src_b, imm, pc);
    modport unit   (input  valid, opcode, tag, src_a, src_b, imm, pc);
endinterface

// req and fields stay steady until the cycle where grant is high
interface fu_result_if;
    logic                             req;
    logic [core_cfg_pkg::tag_len-1:0] tag;
    logic [core_cfg_pkg::xlen-1:0]    value;
    logic                             taken;
    logic                             grant;

    modport unit    (output req, tag, value, taken, input grant);
    modport arbiter (input req, tag, value, taken, output grant);
endinterface

// File: verilog/rob.sv
/* reorder buffer: allocates a tag per dispatch, issues it to the units,
   takes cdb results and retires in order with flush and credit return */
`timescale 1ns/10ps

module rob (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              dispatch_valid,
    input  core_types_pkg::opcode_t           dispatch_opcode,
    input  logic [core_cfg_pkg::reg_len-1:0]  dispatch_dest,
    input  logic [core_cfg_pkg::xlen-1:0]     dispatch_src_a,
    input  logic [core_cfg_pkg::xlen-1:0]     dispatch_src_b,
    input  logic [core_cfg_pkg::xlen-1:0]     dispatch_imm,
    input  logic [core_cfg_pkg::xlen-1:0]     dispatch_pc,
    input  logic                              dispatch_pred_taken,
    input  core_types_pkg::cdb_entry_t        cdb,
    issue_if.issuer                           issue,
    output logic                              credit_return,
    output logic                              retire_valid,
    output logic                              retire_dest_valid,
    output logic [core_cfg_pkg::reg_len-1:0]  retire_dest,
    output logic [core_cfg_pkg::xlen-1:0]     retire_value,
    output logic                              flush,
    output logic [core_cfg_pkg::xlen-1:0]     flush_pc,
    output logic                              halt
);
    logic [core_cfg_pkg::tag_len-1:0]  head;
    logic [core_cfg_pkg::tag_len-1:0]  tail;
    logic [core_cfg_pkg::tag_len:0]    count;
    logic [core_cfg_pkg::rob_size-1:0] ready_q;

    // entry payload
    logic [core_cfg_pkg::reg_len-1:0]  dest_q       [core_cfg_pkg::rob_size];
    logic [core_cfg_pkg::xlen-1:0]     value_q      [core_cfg_pkg::rob_size];
    logic [core_cfg_pkg::xlen-1:0]     pc_q         [core_cfg_pkg::rob_size];
    logic                              pred_taken_q [core_cfg_pkg::rob_size];
    logic                              mispredict_q [core_cfg_pkg::rob_size];
    logic                              halt_q       [core_cfg_pkg::rob_size];

    logic accept;
    logic is_branch;

    //////////////////////////////
    // dispatch and issue
    //////////////////////////////
    // a dispatch offered while flushing is dropped
    assign accept = dispatch_valid && !flush;
    assign is_branch = (dispatch_opcode == core_types_pkg::op_beq) ||
                       (dispatch_opcode == core_types_pkg::op_bne);

    assign issue.valid  = accept;
    assign issue.opcode = dispatch_opcode;
    assign issue.tag    = tail;
    assign issue.src_a  = dispatch_src_a;
    assign issue.src_b  = dispatch_src_b;
    assign issue.imm    = dispatch_imm;
    assign issue.pc     = dispatch_pc;

    //////////////////////////////
    // retire
    //////////////////////////////
    assign retire_valid = (count != '0) && ready_q[head];
    assign retire_dest = dest_q[head];
    assign retire_dest_valid = retire_valid && (dest_q[head] != core_cfg_pkg::zero_reg);
    // a halt has no result, it reports its own pc instead
    assign retire_value = halt_q[head] ? pc_q[head] : value_q[head];
    assign halt = retire_valid && halt_q[head];

    // a branch result is the real next pc, which is the corrected target
    assign flush = retire_valid && mispredict_q[head];
    assign flush_pc = value_q[head];
    assign credit_return = retire_valid && !flush;

    //////////////////////////////
    // pointers and ready bits
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            ready_q <= '0;
        end else begin
            if (retire_valid) begin
                ready_q[head] <= 1'b0;
                head <= head + 1'b1;
            end
            // halt needs no unit, so it is complete at allocation
            if (accept) begin
                ready_q[tail] <= (dispatch_opcode == core_types_pkg::op_halt);
                tail <= tail + 1'b1;
            end
            if (cdb.valid) begin
                ready_q[cdb.tag] <= 1'b1;
            end
            if (accept && !retire_valid) begin
                count <= count + 1'b1;
            end else if (!accept && retire_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry payload, written on allocation and on writeback
    always_ff @(posedge clock) begin
        if (accept) begin
            dest_q[tail] <= dispatch_dest;
            pc_q[tail] <= dispatch_pc;
            pred_taken_q[tail] <= dispatch_pred_taken && is_branch;
            mispredict_q[tail] <= 1'b0;
            halt_q[tail] <= (dispatch_opcode == core_types_pkg::op_halt);
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
            mispredict_q[cdb.tag] <= (cdb.taken != pred_taken_q[cdb.tag]);
        end
    end

endmodule

// File: verilog/exec_unit.sv
/* one execution unit: queues issued ops of its kind in order, computes
   each for the unit latency and holds the result until the cdb grants it */
`timescale 1ns/10ps

module exec_unit #(
    parameter core_types_pkg::unit_kind_t kind = core_types_pkg::kind_alu
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      flush,
    issue_if.unit     issue,
    fu_result_if.unit result
);
    // op queue payload
    core_types_pkg::opcode_t          q_op  [core_cfg_pkg::unit_queue_depth];
    logic [core_cfg_pkg::tag_len-1:0] q_tag [core_cfg_pkg::unit_queue_depth];
    logic [core_cfg_pkg::xlen-1:0]    q_a   [core_cfg_pkg::unit_queue_depth];
    logic [core_cfg_pkg::xlen-1:0]    q_b   [core_cfg_pkg::unit_queue_depth];
    logic [core_cfg_pkg::xlen-1:0]    q_imm [core_cfg_pkg::unit_queue_depth];
    logic [core_cfg_pkg::xlen-1:0]    q_pc  [core_cfg_pkg::unit_queue_depth];

    logic [core_cfg_pkg::tag_len-1:0] wr_ptr;
    logic [core_cfg_pkg::tag_len-1:0] rd_ptr;
    logic [core_cfg_pkg::tag_len:0]   q_count;

    // op being computed or held
    core_types_pkg::opcode_t          cur_op;
    logic [core_cfg_pkg::xlen-1:0]    cur_a;
    logic [core_cfg_pkg::xlen-1:0]    cur_b;
    logic [core_cfg_pkg::xlen-1:0]    cur_imm;
    logic [core_cfg_pkg::xlen-1:0]    cur_pc;

    core_types_pkg::unit_state_t state;
    logic [1:0]                  busy_cnt;
    logic                        is_alu_op;
    logic                        is_br_op;
    logic                        push;
    logic                        pop;
    logic [core_cfg_pkg::xlen-1:0] alu_value;
    logic                        br_taken;

    assign is_alu_op = issue.opcode inside {core_types_pkg::op_add, core_types_pkg::op_sub,
                                            core_types_pkg::op_and, core_types_pkg::op_xor};
    assign is_br_op = issue.opcode inside {core_types_pkg::op_beq, core_types_pkg::op_bne};
    assign push = issue.valid && ((kind == core_types_pkg::kind_alu) ? is_alu_op : is_br_op);
    assign pop = (state == core_types_pkg::st_idle) && (q_count != '0);

    //////////////////////////////
    // compute
    //////////////////////////////
    always_comb begin
        alu_value = '0;
        br_taken = 1'b0;
        case (cur_op)
            core_types_pkg::op_add: alu_value = cur_a + cur_b;
            core_types_pkg::op_sub: alu_value = cur_a - cur_b;
            core_types_pkg::op_and: alu_value = cur_a & cur_b;
            core_types_pkg::op_xor: alu_value = cur_a ^ cur_b;
            core_types_pkg::op_beq: br_taken = (cur_a == cur_b);
            core_types_pkg::op_bne: br_taken = (cur_a != cur_b);
            default: ;
        endcase
    end

    // operands stay put while holding, so the result is steady until grant
    assign result.req = (state == core_types_pkg::st_hold);
    assign result.value = (kind == core_types_pkg::kind_alu) ? alu_value :
                          br_taken ? cur_pc + cur_imm : cur_pc + (core_cfg_pkg::xlen)'(4);
    assign result.taken = (kind == core_types_pkg::kind_branch) && br_taken;

    //////////////////////////////
    // queue and state
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            state <= core_types_pkg::st_idle;
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                q_count <= q_count + 1'b1;
            end else if (!push && pop) begin
                q_count <= q_count - 1'b1;
            end
            case (state)
                core_types_pkg::st_idle: begin
                    if (pop) begin
                        state <= core_types_pkg::st_busy;
                        busy_cnt <= (kind == core_types_pkg::kind_alu) ?
                                    2'(core_cfg_pkg::alu_latency - 1) :
                                    2'(core_cfg_pkg::br_latency - 1);
                    end
                end
                core_types_pkg::st_busy: begin
                    if (busy_cnt == 2'd0) begin
                        state <= core_types_pkg::st_hold;
                    end else begin
                        busy_cnt <= busy_cnt - 2'd1;
                    end
                end
                core_types_pkg::st_hold: begin
                    if (result.grant) begin
                        state <= core_types_pkg::st_idle;
                    end
                end
                default: state <= core_types_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            q_op[wr_ptr] <= issue.opcode;
            q_tag[wr_ptr] <= issue.tag;
            q_a[wr_ptr] <= issue.src_a;
            q_b[wr_ptr] <= issue.src_b;
            q_imm[wr_ptr] <= issue.imm;
            q_pc[wr_ptr] <= issue.pc;
        end
        if (pop) begin
            cur_op <= q_op[rd_ptr];
            result.tag <= q_tag[rd_ptr];
            cur_a <= q_a[rd_ptr];
            cur_b <= q_b[rd_ptr];
            cur_imm <= q_imm[rd_ptr];
            cur_pc <= q_pc[rd_ptr];
        end
    end

endmodule

// File: verilog/cdb_arbiter.sv
/* round-robin grant between the alu and branch units, with the granted
   result registered onto the common data bus one cycle later */
`timescale 1ns/10ps

module cdb_arbiter (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    fu_result_if.arbiter               alu,
    fu_result_if.arbiter               br,
    output core_types_pkg::cdb_entry_t cdb
);
    // set when the branch unit lost the last contested cycle
    logic prefer_br;

    assign alu.grant = alu.req && (!br.req || !prefer_br);
    assign br.grant = br.req && (!alu.req || prefer_br);

    always_ff @(posedge clock) begin
        if (reset) begin
            prefer_br <= 1'b0;
        end else if (alu.req && br.req) begin
            prefer_br <= alu.grant;
        end
    end

    //////////////////////////////
    // registered broadcast
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            cdb <= '0;
        end else if (alu.grant) begin
            cdb <= '{valid: 1'b1, tag: alu.tag, value: alu.value, taken: alu.taken};
        end else if (br.grant) begin
            cdb <= '{valid: 1'b1, tag: br.tag, value: br.value, taken: br.taken};
        end else begin
            cdb.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/ooo_backend_top.sv
/* back end top level: the rob, an alu unit, a branch unit and the
   cdb arbiter behind plain dispatch and retire ports */
`timescale 1ns/10ps

module ooo_backend_top (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             dispatch_valid,
    input  core_types_pkg::opcode_t          dispatch_opcode,
    input  logic [core_cfg_pkg::reg_len-1:0] dispatch_dest,
    input  logic [core_cfg_pkg::xlen-1:0]    dispatch_src_a,
    input  logic [core_cfg_pkg::xlen-1:0]    dispatch_src_b,
    input  logic [core_cfg_pkg::xlen-1:0]    dispatch_imm,
    input  logic [core_cfg_pkg::xlen-1:0]    dispatch_pc,
    input  logic                             dispatch_pred_taken,
    output logic                             credit_return,
    output logic                             retire_valid,
    output logic                             retire_dest_valid,
    output logic [core_cfg_pkg::reg_len-1:0] retire_dest,
    output logic [core_cfg_pkg::xlen-1:0]    retire_value,
    output logic                             flush,
    output logic [core_cfg_pkg::xlen-1:0]    flush_pc,
    output logic                             halt
);
    issue_if                    issue_bus ();
    fu_result_if                alu_res ();
    fu_result_if                br_res ();
    core_types_pkg::cdb_entry_t cdb;

    rob u_rob (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_opcode     (dispatch_opcode),
        .dispatch_dest       (dispatch_dest),
        .dispatch_src_a      (dispatch_src_a),
        .dispatch_src_b      (dispatch_src_b),
        .dispatch_imm        (dispatch_imm),
        .dispatch_pc         (dispatch_pc),
        .dispatch_pred_taken (dispatch_pred_taken),
        .cdb                 (cdb),
        .issue               (issue_bus),
        .credit_return       (credit_return),
        .retire_valid        (retire_valid),
        .retire_dest_valid   (retire_dest_valid),
        .retire_dest         (retire_dest),
        .retire_value        (retire_value),
        .flush               (flush),
        .flush_pc            (flush_pc),
        .halt                (halt)
    );

    exec_unit #(.kind(core_types_pkg::kind_alu)) u_alu (
        .clock  (clock),
        .reset  (reset),
        .flush  (flush),
        .issue  (issue_bus),
        .result (alu_res)
    );

    exec_unit #(.kind(core_types_pkg::kind_branch)) u_branch (
        .clock  (clock),
        .reset  (reset),
        .flush  (flush),
        .issue  (issue_bus),
        .result (br_res)
    );

    cdb_arbiter u_arbiter (
        .clock (clock),
        .reset (reset),
        .flush (flush),
        .alu   (alu_res),
        .br    (br_res),
        .cdb   (cdb)
    );

endmodule

// File: tb/tb_clock_gen.sv
/* testbench clock with an 8 ns period, and a reset held for the first 3 cycles */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    localparam int half_period = 4;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // released 1 ns after the edge, in step with the other stimulus
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
    end
endmodule

// File: tb/rob_chk.sv
/* concurrent checks on rob occupancy and cdb writeback, bound into the rob */
`timescale 1ns/10ps

module rob_chk (
    input logic                              clock,
    input logic                              reset,
    input logic [core_cfg_pkg::tag_len:0]    count,
    input logic [core_cfg_pkg::tag_len-1:0]  head,
    input logic [core_cfg_pkg::rob_size-1:0] ready_q,
    input core_types_pkg::cdb_entry_t        cdb,
    input logic                              dispatch_valid,
    input logic                              flush
);
    // occupancy never passes the buffer size
    a_count_max: assert property (@(posedge clock) disable iff (reset)
        count <= core_cfg_pkg::rob_size)
        else $error("rob occupancy above rob_size");

    // a full rob takes no dispatch, credits forbid it
    a_full_no_dispatch: assert property (@(posedge clock) disable iff (reset)
        (count == core_cfg_pkg::rob_size) |-> !(dispatch_valid && !flush))
        else $error("dispatch accepted while the rob is full");

    // a result only lands on an allocated entry that is still waiting
    a_cdb_pending: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> ((core_cfg_pkg::tag_len'(cdb.tag - head) < count) &&
                       !ready_q[cdb.tag]))
        else $error("cdb result for an entry that is free or already ready");
endmodule

bind rob rob_chk u_rob_chk (
    .clock          (clock),
    .reset          (reset),
    .count          (count),
    .head           (head),
    .ready_q        (ready_q),
    .cdb            (cdb),
    .dispatch_valid (dispatch_valid),
    .flush          (flush)
);

// File: tb/ooo_backend_tb.sv
/* testbench for the back end: dispatches a program table under credit
   control and checks each retirement against a reference queue */
`timescale 1ns/10ps

module ooo_backend_tb;
    localparam int n_rows = 23;
    localparam int cycle_ns = 8;

    // one program row with its expected retirement
    typedef struct {
        core_types_pkg::opcode_t          op;
        logic [core_cfg_pkg::reg_len-1:0] dest;
        logic [core_cfg_pkg::xlen-1:0]    src_a, src_b, imm, pc, exp_value;
        logic                             pred, exp_dv, exp_flush, burst;
    } row_t;

    logic clock;
    logic reset;
    logic dispatch_valid;
    core_types_pkg::opcode_t dispatch_opcode;
    logic [core_cfg_pkg::reg_len-1:0] dispatch_dest;
    logic [core_cfg_pkg::xlen-1:0] dispatch_src_a, dispatch_src_b, dispatch_imm, dispatch_pc;
    logic dispatch_pred_taken;
    logic credit_return, retire_valid, retire_dest_valid, flush, halt;
    logic [core_cfg_pkg::reg_len-1:0] retire_dest;
    logic [core_cfg_pkg::xlen-1:0] retire_value, flush_pc;

    row_t        prog [n_rows];
    int          exp_rows [$];
    int          n_built;
    int          credits;
    int          next_row;
    int          gap;
    logic [31:0] seed;
    logic        offered;
    logic        hit_limit;
    logic        halt_seen;

    tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

    ooo_backend_top u_ooo_backend_top (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // flags are {dest_valid, flush, burst}
    task automatic add_row(input core_types_pkg::opcode_t op, input int dest,
                           input logic [core_cfg_pkg::xlen-1:0] a,
                           input logic [core_cfg_pkg::xlen-1:0] b,
                           input logic [core_cfg_pkg::xlen-1:0] imm,
                           input logic [core_cfg_pkg::xlen-1:0] pc, input int pred,
                           input logic [core_cfg_pkg::xlen-1:0] value, input logic [2:0] flags);
        prog[n_built].op = op;
        prog[n_built].dest = dest[core_cfg_pkg::reg_len-1:0];
        prog[n_built].src_a = a;
        prog[n_built].src_b = b;
        prog[n_built].imm = imm;
        prog[n_built].pc = pc;
        prog[n_built].pred = (pred != 0);
        prog[n_built].exp_value = value;
        prog[n_built].exp_dv = flags[2];
        prog[n_built].exp_flush = flags[1];
        prog[n_built].burst = flags[0];
        n_built++;
    endtask

    task automatic build_program();
        // alu ops, one with the zero register
        add_row(core_types_pkg::op_add, 1, 'h5, 'h7, 0, 'h100, 0, 'hc, 3'b100);
        add_row(core_types_pkg::op_sub, 0, 'h0, 'h1, 0, 'h104, 0, 'hffffffff, 3'b000);
        add_row(core_types_pkg::op_and, 3, 'hf0f0, 'hff00, 0, 'h108, 0, 'hf000, 3'b100);
        add_row(core_types_pkg::op_xor, 4, 'haaaa, 'h5555, 0, 'h10c, 0, 'hffff, 3'b100);
        // correctly predicted branches
        add_row(core_types_pkg::op_beq, 0, 'h5, 'h5, 'h40, 'h110, 1, 'h150, 3'b000);
        add_row(core_types_pkg::op_bne, 0, 'h1, 'h1, 'h20, 'h114, 0, 'h118, 3'b000);
        // branch burst then alu ops back to back, runs the sender out of credits
        add_row(core_types_pkg::op_beq, 0, 'h1, 'h2, 'h10, 'h118, 0, 'h11c, 3'b000);
        add_row(core_types_pkg::op_bne, 0, 'h3, 'h4, 'h8, 'h11c, 1, 'h124, 3'b001);
        add_row(core_types_pkg::op_beq, 0, 'h7, 'h7, 'h30, 'h120, 1, 'h150, 3'b001);
        add_row(core_types_pkg::op_bne, 0, 'h9, 'h9, 'h4, 'h124, 0, 'h128, 3'b001);
        add_row(core_types_pkg::op_add, 6, 'h10, 'h20, 0, 'h128, 0, 'h30, 3'b101);
        add_row(core_types_pkg::op_add, 7, 'h1000, 'h1, 0, 'h12c, 0, 'h1001, 3'b101);
        add_row(core_types_pkg::op_xor, 8, 'hff, 'h0f, 0, 'h130, 0, 'hf0, 3'b101);
        add_row(core_types_pkg::op_and, 9, 'h1234, 'h00ff, 0, 'h134, 0, 'h34, 3'b101);
        add_row(core_types_pkg::op_sub, 10, 'h100, 'h1, 0, 'h138, 0, 'hff, 3'b101);
        add_row(core_types_pkg::op_add, 11, 'h7fffffff, 'h1, 0, 'h13c, 0, 'h80000000, 3'b101);
        // mispredicted branches with younger ops behind them
        add_row(core_types_pkg::op_beq, 0, 'h4, 'h4, 'h80, 'h200, 0, 'h280, 3'b010);
        add_row(core_types_pkg::op_add, 14, 'h1, 'h1, 0, 'h204, 0, 'h2, 3'b101);
        add_row(core_types_pkg::op_sub, 0, 'h5, 'h3, 0, 'h208, 0, 'h2, 3'b001);
        add_row(core_types_pkg::op_bne, 0, 'h6, 'h6, 'h40, 'h20c, 1, 'h210, 3'b011);
        add_row(core_types_pkg::op_xor, 16, 'h3, 'h5, 0, 'h210, 0, 'h6, 3'b101);
        // halt reports its own pc
        add_row(core_types_pkg::op_add, 18, 'h11, 'h22, 0, 'h214, 0, 'h33, 3'b100);
        add_row(core_types_pkg::op_halt, 0, 0, 0, 0, 'h300, 0, 'h300, 3'b000);
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_retire(input logic exp_dv,
                                input logic [core_cfg_pkg::reg_len-1:0] exp_dest,
                                input logic [core_cfg_pkg::xlen-1:0] exp_value);
        if (retire_dest_valid !== exp_dv || (exp_dv && retire_dest !== exp_dest) ||
            retire_value !== exp_value) begin
            abort_run($sformatf("ERROR %0t: retire dv %b dest %0d value %h, expected %b %0d %h",
                                $time, retire_dest_valid, retire_dest, retire_value,
                                exp_dv, exp_dest, exp_value));
        end
    endtask

    task automatic check_flush(input logic exp, input logic [core_cfg_pkg::xlen-1:0] exp_pc);
        if (flush !== exp || (exp && flush_pc !== exp_pc)) begin
            abort_run($sformatf("ERROR %0t: flush %b pc %h, expected %b pc %h",
                                $time, flush, flush_pc, exp, exp_pc));
        end
    endtask

    task automatic check_halt(input logic exp);
        if (halt !== exp) begin
            abort_run($sformatf("ERROR %0t: halt %b, expected %b", $time, halt, exp));
        end
    endtask

    task automatic check_credit(input logic exp);
        if (credit_return !== exp) begin
            abort_run($sformatf("ERROR %0t: credit_return %b, expected %b",
                                $time, credit_return, exp));
        end
    endtask

    //////////////////////////////
    // per cycle driver and monitor
    //////////////////////////////
    task automatic drive_cycle();
        offered = 1'b0;
        if (gap > 0) begin
            gap--;
        end else if (next_row < n_rows && credits > 0) begin
            dispatch_opcode = prog[next_row].op;
            dispatch_dest = prog[next_row].dest;
            dispatch_src_a = prog[next_row].src_a;
            dispatch_src_b = prog[next_row].src_b;
            dispatch_imm = prog[next_row].imm;
            dispatch_pc = prog[next_row].pc;
            dispatch_pred_taken = prog[next_row].pred;
            offered = 1'b1;
            credits--;
            if (credits == 0) begin
                hit_limit = 1'b1;
            end
        end
        dispatch_valid = offered;
    endtask

    task automatic check_cycle();
        int r;
        r = -1;
        if (retire_valid) begin
            if (exp_rows.size() == 0) begin
                abort_run("a retirement came with no dispatch outstanding");
            end
            r = exp_rows.pop_front();
            check_retire(prog[r].exp_dv, prog[r].dest, prog[r].exp_value);
            check_flush(prog[r].exp_flush, prog[r].exp_value);
            check_halt(prog[r].op == core_types_pkg::op_halt);
            check_credit(!prog[r].exp_flush);
            if (halt) begin
                halt_seen = 1'b1;
            end
        end else begin
            check_flush(1'b0, '0);
            check_halt(1'b0);
            check_credit(1'b0);
        end
        if (flush) begin
            // younger ops and this cycle's offer are lost, refetch after the branch
            exp_rows.delete();
            credits = core_cfg_pkg::rob_size;
            next_row = r + 1;
            gap = 0;
        end else begin
            if (credit_return) begin
                credits++;
            end
            if (offered) begin
                exp_rows.push_back(next_row);
                next_row++;
                if (next_row < n_rows && !prog[next_row].burst) begin
                    seed = lcg_next(seed);
                    gap = int'(seed[25:24]);
                end
            end
        end
    endtask

    initial begin
        #(n_rows * 40 * cycle_ns);
        abort_run("watchdog expired before the program finished");
    end

    initial begin
        dispatch_valid = 1'b0;
        dispatch_opcode = core_types_pkg::op_add;
        dispatch_dest = '0;
        dispatch_src_a = '0;
        dispatch_src_b = '0;
        dispatch_imm = '0;
        dispatch_pc = '0;
        dispatch_pred_taken = 1'b0;
        n_built = 0;
        hit_limit = 1'b0;
        halt_seen = 1'b0;
        offered = 1'b0;
        seed = 32'h515b947f;
        credits = core_cfg_pkg::rob_size;
        next_row = 0;
        gap = 0;
        build_program();
        if (n_built != n_rows) begin
            abort_run("program table size does not match n_rows");
        end
        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end
        while (next_row < n_rows || exp_rows.size() != 0) begin
            @(posedge clock);
            #1;
            drive_cycle();
            @(negedge clock);
            check_cycle();
        end
        if (!hit_limit) begin
            abort_run("the sender never ran out of credits");
        end else if (!halt_seen) begin
            abort_run("halt was never seen at retirement");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end
endmodule

// File: sources.f
verilog/core_cfg_pkg.sv
verilog/core_types_pkg.sv
verilog/core_ifs.sv
verilog/rob.sv
verilog/exec_unit.sv
verilog/cdb_arbiter.sv
verilog/ooo_backend_top.sv
tb/tb_clock_gen.sv
tb/rob_chk.sv
tb/ooo_backend_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
		-f sources.f --top-module ooo_backend_tb \
		--Mdir obj_dir -o ooo_backend_sim
	./obj_dir/ooo_backend_sim

clean:
	rm -rf obj_dir
